//--- include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ************************************************************
// datapath sizing
// ************************************************************

// data and address width
`define XLEN 64

// data memory index width, counted in 8-byte words
`define DMEM_AW 8

// ************************************************************
// flow control
// ************************************************************

// ingress buffer depth, also the upstream credit count after reset
`define IN_CREDITS 4

// credits held toward writeback after reset
`define OUT_CREDITS 2

`endif

//--- design/mem_stage_pkg.sv
`include "mem_settings.svh"

package mem_stage_pkg;

    // ************************************************************
    // operation codes
    // ************************************************************

    // memory and writeback operation, decoded upstream in execute
    typedef enum logic [3:0] {
        op_alu,
        op_aluw,
        op_link,
        op_csr,
        op_lb,
        op_lh,
        op_lw,
        op_ld,
        op_lbu,
        op_lhu,
        op_lwu,
        op_sb,
        op_sh,
        op_sw,
        op_sd,
        op_none
    } mem_op_e;

    // ************************************************************
    // stage items
    // ************************************************************

    // item from execute
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
        mem_op_e          op;
        // address for loads and stores
        logic [`XLEN-1:0] alu_out;
        // store data or csr value
        logic [`XLEN-1:0] src2;
    } ex_mem_t;

    // item between access and writeback stages
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
        mem_op_e          op;
        logic [`XLEN-1:0] alu_out;
        logic [`XLEN-1:0] src2;
        // byte offset inside the 8-byte word
        logic [2:0]       offset;
    } access_t;

    // item to writeback
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
        logic             wen;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
    } mem_wb_t;

    // op classification
    function automatic logic is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

endpackage

//--- design/ingress_fifo.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module ingress_fifo
    import mem_stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  ex_mem_t in_item,
    output logic    in_credit,
    output logic    fifo_valid,
    output ex_mem_t fifo_item,
    input  logic    fifo_pop
);

    localparam int DEPTH = `IN_CREDITS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    // entry storage, payload only
    ex_mem_t         buf_q [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;

    // ************************************************************
    // storage and pointers
    // ************************************************************

    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_q[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            // wrap explicitly, depth need not be a power of two
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CW'(in_valid) - CW'(fifo_pop);
            // one credit back per popped entry
            in_credit <= fifo_pop;
        end
    end

    // first-word fall-through head
    assign fifo_valid = (count != '0);
    assign fifo_item  = buf_q[rd_ptr];

    // ************************************************************
    // protocol checks
    // ************************************************************

    // upstream sent without a credit
    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (count != CW'(DEPTH)))
        else $error("ingress push while full, credit violation");

    // access stage popped an empty buffer
    assert property (@(posedge clk) disable iff (rst)
        fifo_pop |-> (count != '0))
        else $error("ingress pop while empty");

endmodule

//--- design/mem_access.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_access
    import mem_stage_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                fifo_valid,
    input  ex_mem_t             fifo_item,
    output logic                fifo_pop,
    input  logic                out_credit,
    output logic                acc_valid,
    output access_t             acc_item,
    output logic                mem_we,
    output logic [7:0]          mem_wmask,
    output logic [`XLEN-1:0]    mem_wdata,
    output logic [`DMEM_AW-1:0] mem_addr
);

    localparam int CW = $clog2(`OUT_CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          issue;
    logic [2:0]    offset;
    // low address bits that must be zero for the access size
    logic [2:0]    align_bits;
    // byte lanes of the access before shifting
    logic [7:0]    base_mask;

    // ************************************************************
    // issue and output credits
    // ************************************************************

    // head leaves only with a writeback slot reserved
    assign issue    = fifo_valid && (credit_cnt != '0);
    assign fifo_pop = issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(`OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CW'(issue) + CW'(out_credit);
        end
    end

    // ************************************************************
    // store alignment
    // ************************************************************

    assign offset = fifo_item.alu_out[2:0];

    always_comb begin
        case (fifo_item.op)
            op_lb, op_lbu, op_sb: begin
                align_bits = 3'b000;
                base_mask  = 8'h01;
            end
            op_lh, op_lhu, op_sh: begin
                align_bits = 3'b001;
                base_mask  = 8'h03;
            end
            op_lw, op_lwu, op_sw: begin
                align_bits = 3'b011;
                base_mask  = 8'h0f;
            end
            default: begin
                // doubleword, and don't-care for register ops
                align_bits = 3'b111;
                base_mask  = 8'hff;
            end
        endcase
    end

    // lanes above the mask are ignored by the memory
    assign mem_we    = issue && is_store(fifo_item.op);
    assign mem_wmask = base_mask << offset;
    assign mem_wdata = fifo_item.src2 << {offset, 3'b000};
    // word index, read registered by the memory at the issue edge
    assign mem_addr  = fifo_item.alu_out[`DMEM_AW+2:3];

    // ************************************************************
    // access register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            acc_item.pc      <= fifo_item.pc;
            acc_item.inst    <= fifo_item.inst;
            acc_item.op      <= fifo_item.op;
            acc_item.alu_out <= fifo_item.alu_out;
            acc_item.src2    <= fifo_item.src2;
            acc_item.offset  <= offset;
        end
    end

    // misaligned accesses are not supported
    assert property (@(posedge clk) disable iff (rst)
        (issue && (is_load(fifo_item.op) || is_store(fifo_item.op)))
        |-> ((offset & align_bits) == 3'b000))
        else $error("misaligned access at pc %h", fifo_item.pc);

    // writeback returned more credits than it was given
    assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CW'(`OUT_CREDITS))
        else $error("output credit overflow");

endmodule

//--- design/data_mem.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_mem (
    input  logic                clk,
    input  logic                we,
    input  logic [7:0]          wmask,
    input  logic [`XLEN-1:0]    wdata,
    input  logic [`DMEM_AW-1:0] addr,
    output logic [`XLEN-1:0]    rdata
);

    localparam int WORDS = 1 << `DMEM_AW;
    localparam int BYTES = `XLEN / 8;

    logic [`XLEN-1:0] mem [WORDS];

    // zero image at start of simulation
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ************************************************************
    // byte-masked write, registered read
    // ************************************************************

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wmask[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        // old contents on a same-edge write
        rdata <= mem[addr];
    end

endmodule

//--- design/load_writeback.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module load_writeback
    import mem_stage_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             acc_valid,
    input  access_t          acc_item,
    input  logic [`XLEN-1:0] rdata,
    output logic             out_valid,
    output mem_wb_t          out_item
);

    // loaded word moved down to the addressed byte
    logic [`XLEN-1:0] shifted;
    logic [`XLEN-1:0] load_val;
    logic [`XLEN-1:0] wb_value;
    logic             wb_wen;

    // ************************************************************
    // load extract and extend
    // ************************************************************

    assign shifted = rdata >> {acc_item.offset, 3'b000};

    always_comb begin
        case (acc_item.op)
            op_lb:   load_val = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            op_lh:   load_val = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            op_lw:   load_val = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
            op_lbu:  load_val = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            op_lhu:  load_val = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            op_lwu:  load_val = {{(`XLEN-32){1'b0}}, shifted[31:0]};
            // doubleword is always at offset zero
            op_ld:   load_val = rdata;
            default: load_val = '0;
        endcase
    end

    // ************************************************************
    // writeback select
    // ************************************************************

    always_comb begin
        if (is_load(acc_item.op)) begin
            wb_value = load_val;
        end else begin
            case (acc_item.op)
                op_alu:  wb_value = acc_item.alu_out;
                // 32-bit result, sign extended
                op_aluw: wb_value = {{(`XLEN-32){acc_item.alu_out[31]}},
                                     acc_item.alu_out[31:0]};
                // return address
                op_link: wb_value = acc_item.pc + `XLEN'd4;
                // csr value arrives in src2
                op_csr:  wb_value = acc_item.src2;
                default: wb_value = '0;
            endcase
        end
    end

    // stores and bubbles write no register
    assign wb_wen = !(is_store(acc_item.op) || (acc_item.op == op_none));

    // ************************************************************
    // output register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            out_item.pc    <= acc_item.pc;
            out_item.inst  <= acc_item.inst;
            out_item.wen   <= wb_wen;
            out_item.rd    <= acc_item.inst[11:7];
            out_item.value <= wb_value;
        end
    end

endmodule

//--- design/mem_stage_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  ex_mem_t in_item,
    output logic    in_credit,
    output logic    out_valid,
    output mem_wb_t out_item,
    input  logic    out_credit
);

    // ingress to access
    logic                fifo_valid;
    ex_mem_t             fifo_item;
    logic                fifo_pop;

    // access to writeback
    logic                acc_valid;
    access_t             acc_item;

    // memory port
    logic                mem_we;
    logic [7:0]          mem_wmask;
    logic [`XLEN-1:0]    mem_wdata;
    logic [`DMEM_AW-1:0] mem_addr;
    logic [`XLEN-1:0]    mem_rdata;

    // ************************************************************
    // input side
    // ************************************************************

    ingress_fifo u_ingress (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_item    (in_item),
        .in_credit  (in_credit),
        .fifo_valid (fifo_valid),
        .fifo_item  (fifo_item),
        .fifo_pop   (fifo_pop)
    );

    // ************************************************************
    // access, memory and writeback
    // ************************************************************

    mem_access u_access (
        .clk        (clk),
        .rst        (rst),
        .fifo_valid (fifo_valid),
        .fifo_item  (fifo_item),
        .fifo_pop   (fifo_pop),
        .out_credit (out_credit),
        .acc_valid  (acc_valid),
        .acc_item   (acc_item),
        .mem_we     (mem_we),
        .mem_wmask  (mem_wmask),
        .mem_wdata  (mem_wdata),
        .mem_addr   (mem_addr)
    );

    data_mem u_dmem (
        .clk   (clk),
        .we    (mem_we),
        .wmask (mem_wmask),
        .wdata (mem_wdata),
        .addr  (mem_addr),
        .rdata (mem_rdata)
    );

    // rdata lines up with the acc registers
    load_writeback u_wb (
        .clk       (clk),
        .rst       (rst),
        .acc_valid (acc_valid),
        .acc_item  (acc_item),
        .rdata     (mem_rdata),
        .out_valid (out_valid),
        .out_item  (out_item)
    );

endmodule

//--- verif/mem_stage_checker.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_stage_checker
    import mem_stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  ex_mem_t in_item,
    input  logic    in_credit,
    input  logic    out_valid,
    input  mem_wb_t out_item,
    input  logic    out_credit,
    output int      errors,
    output int      checked
);

    localparam int WORDS = 1 << `DMEM_AW;

    // model of the data memory updated in arrival order
    logic [`XLEN-1:0] model_mem [WORDS];
    mem_wb_t          expect_q [$];
    mem_wb_t          exp_item;
    logic [`XLEN-1:0] word;
    int               items_in;
    int               in_returns;
    // credits the DUT holds toward writeback as seen from outside
    int               out_held;
    logic             started;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            model_mem[i] = '0;
        end
    end

    // ************************************************************
    // reference model
    // ************************************************************

    function automatic int access_bytes(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] sign_extend(logic [`XLEN-1:0] v, int bits);
        logic signed [`XLEN-1:0] s;
        s = v << (`XLEN - bits);
        return s >>> (`XLEN - bits);
    endfunction

    function automatic logic [`XLEN-1:0] zero_extend(logic [`XLEN-1:0] v, int bits);
        return v & ((`XLEN'd1 << bits) - `XLEN'd1);
    endfunction

    function automatic logic [`DMEM_AW-1:0] word_index(logic [`XLEN-1:0] addr);
        return addr[`DMEM_AW+2:3];
    endfunction

    // expected writeback item from the model word before this item
    function automatic mem_wb_t ref_result(ex_mem_t it, logic [`XLEN-1:0] word_in);
        mem_wb_t          r;
        logic [`XLEN-1:0] field;
        int               nbits;
        // addressed field moved down to bit 0
        field   = word_in >> (8 * it.alu_out[2:0]);
        nbits   = 8 * access_bytes(it.op);
        r.pc    = it.pc;
        r.inst  = it.inst;
        r.rd    = it.inst[11:7];
        r.wen   = 1'b1;
        r.value = '0;
        case (it.op)
            op_alu:                 r.value = it.alu_out;
            op_aluw:                r.value = sign_extend(it.alu_out, 32);
            op_link:                r.value = it.pc + `XLEN'd4;
            op_csr:                 r.value = it.src2;
            op_lb, op_lh, op_lw:    r.value = sign_extend(field, nbits);
            op_lbu, op_lhu, op_lwu: r.value = zero_extend(field, nbits);
            op_ld:                  r.value = word_in;
            // stores and bubbles
            default:                r.wen = 1'b0;
        endcase
        return r;
    endfunction

    // low bytes of src2 land at the addressed lanes
    task automatic merge_store(ex_mem_t it);
        logic [`DMEM_AW-1:0] idx;
        int                  off;
        idx = word_index(it.alu_out);
        off = int'(it.alu_out[2:0]);
        for (int b = 0; b < access_bytes(it.op); b++) begin
            model_mem[idx][(off + b)*8 +: 8] = it.src2[b*8 +: 8];
        end
    endtask

    // ************************************************************
    // monitor and compare
    // ************************************************************

    always @(posedge clk) begin
        if (rst) begin
            expect_q.delete();
            items_in   = 0;
            in_returns = 0;
            out_held   = `OUT_CREDITS;
            started    = 1'b0;
            errors     = 0;
            checked    = 0;
        end else begin
            // stage must stay quiet until something is sent
            if (!started && (out_valid || in_credit)) begin
                $display("%0t: stage output active before the first item was sent", $time);
                errors++;
            end
            // input side
            if (in_valid) begin
                word = model_mem[word_index(in_item.alu_out)];
                expect_q.push_back(ref_result(in_item, word));
                if (in_item.op inside {op_sb, op_sh, op_sw, op_sd}) begin
                    merge_store(in_item);
                end
                items_in++;
                started = 1'b1;
            end
            if (in_credit) begin
                in_returns++;
            end
            if (in_returns > items_in) begin
                $display("%0t: ingress returned a credit for an item never sent", $time);
                errors++;
            end
            // output side
            if (out_valid) begin
                if (out_held == 0) begin
                    $display("%0t: out_valid while the stage held no output credit", $time);
                    errors++;
                end
                if (expect_q.size() == 0) begin
                    $display("%0t: output item with nothing expected", $time);
                    errors++;
                end else begin
                    exp_item = expect_q.pop_front();
                    checked++;
                    if (out_item !== exp_item) begin
                        $display("[FAIL] %0t: got pc %h rd %0d wen %b value %h",
                                 $time, out_item.pc, out_item.rd, out_item.wen,
                                 out_item.value);
                        $display("[FAIL] %0t: expected pc %h rd %0d wen %b value %h",
                                 $time, exp_item.pc, exp_item.rd, exp_item.wen,
                                 exp_item.value);
                        errors++;
                    end
                end
            end
            out_held = out_held - int'(out_valid) + int'(out_credit);
        end
    end

endmodule

//--- verif/tb_mem_stage.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_stage
    import mem_stage_pkg::*;
();

    logic    clk;
    logic    rst;
    logic    in_valid;
    ex_mem_t in_item;
    logic    in_credit;
    logic    out_valid;
    mem_wb_t out_item;
    logic    out_credit;

    int      seed;
    ex_mem_t items [$];
    // downstream credit delay per output item
    int      ret_delay [$];
    int      ret_due [$];
    int      n_items;
    int      limit;
    int      idx;
    int      held;
    int      cycles;
    int      up_returns;
    int      out_seen;
    int      due;
    int      flow_errors;
    int      chk_errors;
    int      checked;

    mem_stage_top uut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_item    (in_item),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_item   (out_item),
        .out_credit (out_credit)
    );

    mem_stage_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_item    (in_item),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_item   (out_item),
        .out_credit (out_credit),
        .errors     (chk_errors),
        .checked    (checked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ************************************************************
    // stimulus generation
    // ************************************************************

    function automatic logic [`XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [`XLEN-1:0] addr_of(int word, int off);
        return `XLEN'(word * 8 + off);
    endfunction

    function automatic int op_bytes(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    task automatic add_item(mem_op_e op, logic [`XLEN-1:0] alu_out, logic [`XLEN-1:0] src2);
        ex_mem_t it;
        it.pc      = rand64() & ~`XLEN'h3;
        it.inst    = $random(seed);
        it.op      = op;
        it.alu_out = alu_out;
        it.src2    = src2;
        items.push_back(it);
        // mostly quick returns, now and then a long stall
        ret_delay.push_back((($random(seed) & 3) == 0) ? ($random(seed) & 15) : 0);
    endtask

    task automatic build_items();
        mem_op_e reg_ops [4] = '{op_alu, op_aluw, op_link, op_csr};
        mem_op_e st_ops [4]  = '{op_sb, op_sh, op_sw, op_sd};
        mem_op_e ld_ops [7]  = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
        mem_op_e op;
        int      size;
        int      off;
        // register ops, then one bubble
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 3; k++) begin
                add_item(reg_ops[i], rand64(), rand64());
            end
        end
        add_item(op_none, rand64(), rand64());
        // every store width at every aligned offset, read back whole word
        for (int w = 0; w < 4; w++) begin
            for (int o = 0; o < 8; o += op_bytes(st_ops[w])) begin
                add_item(st_ops[w], addr_of(1, o), rand64());
                add_item(op_ld, addr_of(1, 0), rand64());
            end
        end
        // mixed-sign pattern, every load kind at every aligned offset
        add_item(op_sd, addr_of(2, 0), 64'hf07f_8001_7ffe_81c3);
        for (int l = 0; l < 7; l++) begin
            for (int o = 0; o < 8; o += op_bytes(ld_ops[l])) begin
                add_item(ld_ops[l], addr_of(2, o), rand64());
            end
        end
        // random mix over a few words
        for (int i = 0; i < 150; i++) begin
            op   = mem_op_e'(4'($random(seed)));
            size = op_bytes(op);
            off  = ($random(seed) & 7) & ~(size - 1);
            if (op inside {op_alu, op_aluw, op_link, op_csr, op_none}) begin
                add_item(op, rand64(), rand64());
            end else begin
                add_item(op, addr_of($random(seed) & 7, off), rand64());
            end
        end
    endtask

    // ************************************************************
    // credit bookkeeping and cycle count
    // ************************************************************

    always @(posedge clk) begin
        if (rst) begin
            cycles     <= 0;
            up_returns <= 0;
        end else begin
            cycles <= cycles + 1;
            if (in_credit) begin
                up_returns <= up_returns + 1;
            end
        end
    end

    // writeback side hands each credit back after a random delay
    always @(posedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
            out_seen = 0;
            ret_due.delete();
        end else begin
            out_credit <= 1'b0;
            if (out_valid) begin
                due = cycles + ((out_seen < ret_delay.size()) ? ret_delay[out_seen] : 0);
                // one pulse per cycle, keep returns in order
                if (ret_due.size() > 0 && due <= ret_due[$]) begin
                    due = ret_due[$] + 1;
                end
                ret_due.push_back(due);
                out_seen++;
            end
            if (ret_due.size() > 0 && ret_due[0] <= cycles) begin
                out_credit <= 1'b1;
                void'(ret_due.pop_front());
            end
        end
    end

    // ************************************************************
    // main sequence
    // ************************************************************

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_item     = '0;
        out_credit  = 1'b0;
        seed        = 32'h8501_7fb8;
        flow_errors = 0;
        idx         = 0;
        build_items();
        n_items = items.size();
        limit   = 40 * n_items + 200;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // idle window, stage must stay quiet
        repeat (5) @(posedge clk);
        // send only while holding an ingress credit
        while (idx < n_items && cycles < limit) begin
            @(posedge clk);
            held = `IN_CREDITS - idx + up_returns;
            if (held > 0 && ($random(seed) & 3) != 0) begin
                in_valid <= 1'b1;
                in_item  <= items[idx];
                idx++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while ((checked < n_items || up_returns < n_items) && cycles < limit) begin
            @(negedge clk);
        end
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d items out", cycles, checked, n_items);
            flow_errors++;
        end
        // upstream balance must be back to the full ingress depth
        if (`IN_CREDITS - idx + up_returns != `IN_CREDITS) begin
            $display("upstream holds %0d credits at the end, %0d sent, %0d returned",
                     `IN_CREDITS - idx + up_returns, idx, up_returns);
            flow_errors++;
        end
        $display("errors: %0d in checker, %0d in flow control, %0d of %0d items checked",
                 chk_errors, flow_errors, checked, n_items);
        if (chk_errors == 0 && flow_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
design/mem_stage_pkg.sv
design/ingress_fifo.sv
design/mem_access.sv
design/data_mem.sv
design/load_writeback.sv
design/mem_stage_top.sv
verif/mem_stage_checker.sv
verif/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module tb_mem_stage \
    -o sim_mem_stage

./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
